//--- io_params.svh
`ifndef IO_PARAMS_SVH
`define IO_PARAMS_SVH

// address map of the board I/O slave
`define IO_NUM_DIGITS 8
`define IO_LEFT_ADDR  8
`define IO_RIGHT_ADDR 9

// buttons occupy one address each, starting here
`define IO_PB_ADDR 10
`define IO_NUM_PB  21

// command queue entries
`define IO_FIFO_DEPTH 4

// glyph 0, segments a to f lit
`define IO_SEG_RESET 8'h3F

`endif

//--- ioPkg.sv
package ioPkg;

  // one host command
  typedef struct packed {
    logic       write;
    logic [7:0] addr;
    logic [7:0] data;
  } ioCmd_t;

  // read response byte
  typedef logic [7:0] ioRsp_t;

  // wishbone classic, master to slave
  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    logic [7:0] adr;
    logic [7:0] dat;
  } wbReq_t;

  // wishbone classic, slave to master
  typedef struct packed {
    logic       ack;
    logic [7:0] dat;
  } wbRsp_t;

  // named segments, dp in the high bit
  typedef struct packed {
    logic dp;
    logic g;
    logic f;
    logic e;
    logic d;
    logic c;
    logic b;
    logic a;
  } segBits_t;

  // one digit, seen as a byte or as segments
  typedef union packed {
    logic [7:0] raw;
    segBits_t   seg;
  } segPattern_u;

endpackage

//--- segDecoder.sv
module segDecoder (
  input  logic [7:0]         code,
  output ioPkg::segPattern_u pattern
);

  // glyph table, bit 7 is dp and bit 0 is segment a
  always_comb begin
    case (code)
      8'd0:    pattern.raw = 8'h3F;
      8'd1:    pattern.raw = 8'h06;
      8'd2:    pattern.raw = 8'h5B;
      8'd3:    pattern.raw = 8'h4F;
      8'd4:    pattern.raw = 8'h66;
      8'd5:    pattern.raw = 8'h6D;
      8'd6:    pattern.raw = 8'h7D;
      8'd7:    pattern.raw = 8'h07;
      8'd8:    pattern.raw = 8'h7F;
      8'd9:    pattern.raw = 8'h6F;
      // hex letters A to F
      8'd10:   pattern.raw = 8'h77;
      8'd11:   pattern.raw = 8'h7C;
      8'd12:   pattern.raw = 8'h39;
      8'd13:   pattern.raw = 8'h5E;
      8'd14:   pattern.raw = 8'h79;
      8'd15:   pattern.raw = 8'h71;
      // H
      8'd16:   pattern.raw = 8'h76;
      // U shape
      8'd17:   pattern.raw = 8'h3E;
      // small o
      8'd18:   pattern.raw = 8'h5C;
      // r
      8'd19:   pattern.raw = 8'h50;
      // r with decimal point
      8'd21:   pattern.raw = 8'hD0;
      // unknown codes light only the decimal point
      default: pattern.raw = 8'h80;
    endcase
  end

endmodule

//--- cmdFifo.sv
`include "io_params.svh"

module cmdFifo (
  input  logic          clk,
  input  logic          nrst,
  input  logic          inValid,
  output logic          inReady,
  input  ioPkg::ioCmd_t inCmd,
  output logic          outValid,
  input  logic          outReady,
  output ioPkg::ioCmd_t outCmd,
  output logic          empty
);
  import ioPkg::*;

  localparam int depth = `IO_FIFO_DEPTH;
  localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
  localparam int cntW = $clog2(depth + 1);

  ioCmd_t mem [depth];
  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [cntW-1:0] count;
  logic push;
  logic pop;

  assign inReady  = (count != cntW'(depth));
  assign outValid = (count != '0);
  assign empty    = (count == '0);
  assign outCmd   = mem[rdPtr];

  assign push = inValid && inReady;
  assign pop  = outValid && outReady;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wrPtr] <= inCmd;
    end
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      // pointers wrap at the last entry
      if (push) begin
        wrPtr <= (wrPtr == ptrW'(depth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= (rdPtr == ptrW'(depth - 1)) ? '0 : rdPtr + 1'b1;
      end
      // push and pop together leave the count as is
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- wbMaster.sv
module wbMaster (
  input  logic          clk,
  input  logic          nrst,
  input  logic          cmdValid,
  output logic          cmdReady,
  input  ioPkg::ioCmd_t cmd,
  output ioPkg::wbReq_t wbReq,
  input  ioPkg::wbRsp_t wbRsp,
  output logic          rspValid,
  output ioPkg::ioRsp_t rsp,
  output logic          busy
);

  typedef enum logic [1:0] {
    sIdle,
    sActive,
    sResp
  } masterState_t;

  masterState_t state;

  // one command in flight at a time
  assign cmdReady = (state == sIdle);
  assign busy     = (state != sIdle);

  // we is still held from the finished transfer
  assign rspValid = (state == sResp) && !wbReq.we;

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      state <= sIdle;
      wbReq <= '0;
    end else begin
      case (state)
        sIdle: begin
          if (cmdValid) begin
            wbReq.cyc <= 1'b1;
            wbReq.stb <= 1'b1;
            wbReq.we  <= cmd.write;
            wbReq.adr <= cmd.addr;
            wbReq.dat <= cmd.data;
            state     <= sActive;
          end
        end
        sActive: begin
          // address and data stay put until ack
          if (wbRsp.ack) begin
            wbReq.cyc <= 1'b0;
            wbReq.stb <= 1'b0;
            state     <= sResp;
          end
        end
        sResp: begin
          // bus idle for this cycle
          state <= sIdle;
        end
        default: begin
          state <= sIdle;
        end
      endcase
    end
  end

  // read data sampled on ack
  always_ff @(posedge clk) begin
    if ((state == sActive) && wbRsp.ack && !wbReq.we) begin
      rsp <= wbRsp.dat;
    end
  end

endmodule

//--- ioDriver.sv
`include "io_params.svh"

module ioDriver (
  input  logic                  clk,
  input  logic                  nrst,
  input  ioPkg::wbReq_t         wbReq,
  output ioPkg::wbRsp_t         wbRsp,
  input  logic [`IO_NUM_PB-1:0] pb,
  output ioPkg::segPattern_u    segs [`IO_NUM_DIGITS],
  output logic [7:0]            left,
  output logic [7:0]            right
);
  import ioPkg::*;

  localparam int digitW = $clog2(`IO_NUM_DIGITS);
  localparam int pbW = $clog2(`IO_NUM_PB);

  segPattern_u decoded;
  logic ackReg;
  logic strobe;
  logic wrStrobe;
  logic isPb;
  logic [7:0] pbIdx;
  logic [7:0] rdMux;
  logic [7:0] rdData;

  // glyph code arrives on the write data lines
  segDecoder decoder (
    .code    (wbReq.dat),
    .pattern (decoded)
  );

  // a transfer is taken once, ack then ends it
  assign strobe   = wbReq.cyc && wbReq.stb && !ackReg;
  assign wrStrobe = strobe && wbReq.we;

  // button window starts at the first button address
  assign pbIdx = wbReq.adr - 8'(`IO_PB_ADDR);
  assign isPb  = (wbReq.adr >= 8'(`IO_PB_ADDR)) && (pbIdx < 8'(`IO_NUM_PB));

  always_comb begin
    rdMux = 8'h00;
    if (isPb) begin
      rdMux = {7'b0, pb[pbIdx[pbW-1:0]]};
    end
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      ackReg <= 1'b0;
      left   <= '0;
      right  <= '0;
      for (int i = 0; i < `IO_NUM_DIGITS; i++) begin
        segs[i].raw <= `IO_SEG_RESET;
      end
    end else begin
      ackReg <= strobe;
      if (wrStrobe) begin
        // digits take the decoded glyph, LEDs the raw byte
        if (wbReq.adr < 8'(`IO_NUM_DIGITS)) begin
          segs[wbReq.adr[digitW-1:0]] <= decoded;
        end else if (wbReq.adr == 8'(`IO_LEFT_ADDR)) begin
          left <= wbReq.dat;
        end else if (wbReq.adr == 8'(`IO_RIGHT_ADDR)) begin
          right <= wbReq.dat;
        end
      end
    end
  end

  // read data lines up with ack
  always_ff @(posedge clk) begin
    if (strobe) begin
      rdData <= rdMux;
    end
  end

  assign wbRsp.ack = ackReg;
  assign wbRsp.dat = rdData;

endmodule

//--- ioSubsystem.sv
`include "io_params.svh"

module ioSubsystem (
  input  logic                  clk,
  input  logic                  nrst,
  input  logic                  cmdValid,
  output logic                  cmdReady,
  input  ioPkg::ioCmd_t         cmd,
  output logic                  rspValid,
  output ioPkg::ioRsp_t         rsp,
  output logic                  idle,
  input  logic [`IO_NUM_PB-1:0] pb,
  output ioPkg::segPattern_u    segs [`IO_NUM_DIGITS],
  output logic [7:0]            left,
  output logic [7:0]            right
);
  import ioPkg::*;

  ioCmd_t fifoCmd;
  logic fifoValid;
  logic fifoReady;
  logic fifoEmpty;
  logic masterBusy;
  wbReq_t wbReq;
  wbRsp_t wbRsp;

  // host commands queue here
  cmdFifo cmdQueue (
    .clk      (clk),
    .nrst     (nrst),
    .inValid  (cmdValid),
    .inReady  (cmdReady),
    .inCmd    (cmd),
    .outValid (fifoValid),
    .outReady (fifoReady),
    .outCmd   (fifoCmd),
    .empty    (fifoEmpty)
  );

  wbMaster master (
    .clk      (clk),
    .nrst     (nrst),
    .cmdValid (fifoValid),
    .cmdReady (fifoReady),
    .cmd      (fifoCmd),
    .wbReq    (wbReq),
    .wbRsp    (wbRsp),
    .rspValid (rspValid),
    .rsp      (rsp),
    .busy     (masterBusy)
  );

  ioDriver driver (
    .clk   (clk),
    .nrst  (nrst),
    .wbReq (wbReq),
    .wbRsp (wbRsp),
    .pb    (pb),
    .segs  (segs),
    .left  (left),
    .right (right)
  );

  // nothing queued and no transfer running
  assign idle = fifoEmpty && !masterBusy;

endmodule

//--- tb_ioSubsystem.sv
`include "io_params.svh"

module tb_ioSubsystem;
  import ioPkg::*;

  // commands issued by all tests, used to size the watchdog
  localparam int cmdTotal = 24 + 8 + 225 + 256 + 16;
  localparam int timeoutCycles = cmdTotal * 20 + 100;
  localparam int waitLimit = 50;

  logic clk;
  logic nrst;
  logic cmdValid;
  logic cmdReady;
  ioCmd_t cmd;
  logic rspValid;
  ioRsp_t rsp;
  logic idle;
  logic [`IO_NUM_PB-1:0] pb;
  segPattern_u segs [`IO_NUM_DIGITS];
  logic [7:0] left;
  logic [7:0] right;

  // reference model of the slave registers
  segPattern_u expSegs [`IO_NUM_DIGITS];
  logic [7:0] expLeft;
  logic [7:0] expRight;

  logic [31:0] rngState;
  int stallCount;

  ioSubsystem dut0 (
    .clk      (clk),
    .nrst     (nrst),
    .cmdValid (cmdValid),
    .cmdReady (cmdReady),
    .cmd      (cmd),
    .rspValid (rspValid),
    .rsp      (rsp),
    .idle     (idle),
    .pb       (pb),
    .segs     (segs),
    .left     (left),
    .right    (right)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    repeat (timeoutCycles) @(posedge clk);
    $display("watchdog expired before the tests finished");
    $display("=== FAIL ===");
    $fatal(1);
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] randWord();
    rngState = xorshift(rngState);
    return rngState;
  endfunction

  // expected segment byte per glyph code with dp in bit 7
  function automatic logic [7:0] glyphFor(input int code);
    case (code)
      0:       return 8'h3F;
      1:       return 8'h06;
      2:       return 8'h5B;
      3:       return 8'h4F;
      4:       return 8'h66;
      5:       return 8'h6D;
      6:       return 8'h7D;
      7:       return 8'h07;
      8:       return 8'h7F;
      9:       return 8'h6F;
      10:      return 8'h77;
      11:      return 8'h7C;
      12:      return 8'h39;
      13:      return 8'h5E;
      14:      return 8'h79;
      15:      return 8'h71;
      16:      return 8'h76;
      17:      return 8'h3E;
      18:      return 8'h5C;
      19:      return 8'h50;
      21:      return 8'hD0;
      default: return 8'h80;
    endcase
  endfunction

  // buttons answer in bit 0, everything else reads zero
  function automatic ioRsp_t expectedRead(input int a);
    ioRsp_t r;
    r = '0;
    if ((a >= `IO_PB_ADDR) && (a < `IO_PB_ADDR + `IO_NUM_PB)) begin
      r[0] = pb[a - `IO_PB_ADDR];
    end
    return r;
  endfunction

  task automatic reportFailure(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic checkSeg(input string name, input segPattern_u exp, input segPattern_u act);
    if (exp !== act) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp.raw, act.raw);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  task automatic checkLed(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (exp !== act) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  task automatic checkRsp(input string name, input ioRsp_t exp, input ioRsp_t act);
    if (exp !== act) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  task automatic checkOutputs();
    for (int i = 0; i < `IO_NUM_DIGITS; i++) begin
      checkSeg($sformatf("segs[%0d]", i), expSegs[i], segs[i]);
    end
    checkLed("left", expLeft, left);
    checkLed("right", expRight, right);
  endtask

  // called on a falling edge, returns on the falling edge after the push
  task automatic pushCmd(input ioCmd_t c);
    cmd = c;
    cmdValid = 1'b1;
    while (!cmdReady) begin
      stallCount++;
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  task automatic waitIdle();
    int n;
    n = 0;
    while (!idle) begin
      if (n > waitLimit) begin
        reportFailure("idle never came back after a command");
      end
      @(negedge clk);
      n++;
    end
  endtask

  task automatic waitResponse(output ioRsp_t data);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > waitLimit * 8) begin
        reportFailure("no read response arrived");
      end
    end while (!rspValid);
    data = rsp;
  endtask

  task automatic writeReg(input int a, input logic [7:0] d);
    ioCmd_t c;
    c.write = 1'b1;
    c.addr = 8'(a);
    c.data = d;
    pushCmd(c);
    cmdValid = 1'b0;
    waitIdle();
  endtask

  task automatic readReg(input int a, output ioRsp_t d);
    ioCmd_t c;
    c.write = 1'b0;
    c.addr = 8'(a);
    c.data = 8'(randWord());
    pushCmd(c);
    cmdValid = 1'b0;
    waitResponse(d);
  endtask

  task automatic afterResetState();
    checkOutputs();
    if (!idle) begin
      reportFailure("idle is low after reset");
    end
    if (!cmdReady) begin
      reportFailure("cmdReady is low after reset");
    end
    if (rspValid) begin
      reportFailure("rspValid is high after reset");
    end
  endtask

  task automatic glyphWrites();
    int d;
    for (int code = 0; code < 24; code++) begin
      d = int'(randWord() % `IO_NUM_DIGITS);
      writeReg(d, 8'(code));
      expSegs[d].raw = glyphFor(code);
      checkOutputs();
    end
  endtask

  task automatic ledAndUnmappedWrites();
    logic [7:0] v;
    for (int i = 0; i < 4; i++) begin
      v = 8'(randWord());
      writeReg(`IO_LEFT_ADDR, v);
      expLeft = v;
      checkOutputs();
      v = 8'(randWord());
      writeReg(`IO_RIGHT_ADDR, v);
      expRight = v;
      checkOutputs();
    end
    // nothing above the button window is mapped for writes
    for (int a = 31; a < 256; a++) begin
      writeReg(a, 8'(randWord()));
      checkOutputs();
    end
  endtask

  task automatic buttonReads();
    logic [31:0] r;
    ioRsp_t got;
    r = randWord();
    pb = r[`IO_NUM_PB-1:0];
    @(negedge clk);
    for (int a = 0; a < 256; a++) begin
      readReg(a, got);
      checkRsp($sformatf("rsp from addr %0d", a), expectedRead(a), got);
    end
  endtask

  task automatic burstTraffic();
    ioCmd_t cmds [$];
    ioRsp_t expRsp [$];
    ioCmd_t c;
    logic [31:0] r;
    int a;
    int numReads;
    r = randWord();
    pb = r[`IO_NUM_PB-1:0];
    stallCount = 0;
    numReads = 0;
    // build the command list and advance the model in issue order
    for (int i = 0; i < 16; i++) begin
      r = randWord();
      if (r[1:0] < 2'd2) begin
        a = int'(r[15:8] % 10);
        c.write = 1'b1;
        c.addr = 8'(a);
        if (a < `IO_NUM_DIGITS) begin
          c.data = 8'(r[31:16] % 24);
          expSegs[a].raw = glyphFor(int'(c.data));
        end else begin
          c.data = r[23:16];
          if (a == `IO_LEFT_ADDR) begin
            expLeft = c.data;
          end else begin
            expRight = c.data;
          end
        end
      end else begin
        a = int'(r[15:8] % 40);
        c.write = 1'b0;
        c.addr = 8'(a);
        c.data = r[23:16];
        expRsp.push_back(expectedRead(a));
        numReads++;
      end
      cmds.push_back(c);
    end
    fork
      begin
        foreach (cmds[i]) begin
          pushCmd(cmds[i]);
        end
        cmdValid = 1'b0;
      end
      begin
        ioRsp_t got;
        for (int k = 0; k < numReads; k++) begin
          waitResponse(got);
          checkRsp($sformatf("burst rsp %0d", k), expRsp.pop_front(), got);
        end
      end
    join
    waitIdle();
    checkOutputs();
    if (stallCount == 0) begin
      reportFailure("burst never saw cmdReady low");
    end
  endtask

  initial begin
    nrst = 1'b0;
    cmdValid = 1'b0;
    cmd = '0;
    pb = '0;
    rngState = 32'hafa77821;
    stallCount = 0;
    for (int i = 0; i < `IO_NUM_DIGITS; i++) begin
      expSegs[i].raw = `IO_SEG_RESET;
    end
    expLeft = '0;
    expRight = '0;

    repeat (5) @(posedge clk);
    @(negedge clk);
    nrst = 1'b1;
    @(negedge clk);

    afterResetState();
    glyphWrites();
    ledAndUnmappedWrites();
    buttonReads();
    burstTraffic();

    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- sim.f
+incdir+.
ioPkg.sv
segDecoder.sv
cmdFifo.sv
wbMaster.sv
ioDriver.sv
ioSubsystem.sv
tb_ioSubsystem.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_ioSubsystem
FILELIST  = sim.f
OBJDIR    = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
